// ==== hw/ctrlPkg.sv ====
package ctrlPkg;

  // Opcodes handled by the controller
  localparam logic [5:0] opNull = 6'h00; // R-type, decoded by funct
  localparam logic [5:0] opBeq  = 6'h04;
  localparam logic [5:0] opBne  = 6'h05;
  localparam logic [5:0] opBle  = 6'h06;
  localparam logic [5:0] opBgt  = 6'h07;
  localparam logic [5:0] opAddi = 6'h08;

  // Funct codes under opNull
  localparam logic [5:0] fnAdd = 6'h20;
  localparam logic [5:0] fnSub = 6'h22;
  localparam logic [5:0] fnAnd = 6'h24;

  // Step counter
  localparam int stepWidth = 3;
  typedef logic [stepWidth-1:0] step_t;

  localparam step_t fetchLast      = 3'd5; // Decode step
  localparam step_t aluExecLast    = 3'd2;
  localparam step_t branchExecLast = 3'd3;

  typedef enum logic [3:0] {
    phReset,
    phFetch,
    phAdd,
    phAddi,
    phSub,
    phAnd,
    phBeq,
    phBne,
    phBle,
    phBgt
  } phase_t;

  // ALU operation, same codes as the datapath ALU
  typedef enum logic [2:0] {
    aluNone = 3'd0,
    aluAdd  = 3'd1,
    aluSub  = 3'd2,
    aluAnd  = 3'd3,
    aluCmp  = 3'd7 // Compare only, drives EQ/GT
  } aluOp_t;

  typedef enum logic [1:0] {
    srcAPc = 2'd0,
    srcAA  = 2'd1
  } srcA_t;

  typedef enum logic [1:0] {
    srcBB      = 2'd0,
    srcBFour   = 2'd1,
    srcBImm    = 2'd2, // Sign-extended immediate
    srcBBranch = 2'd3  // Immediate shifted by two
  } srcB_t;

  typedef enum logic [1:0] {
    dstRt = 2'd0,
    dstRd = 2'd1
  } regDst_t;

  typedef enum logic [2:0] {
    pcNone      = 3'd0,
    pcAluResult = 3'd1,
    pcAluOut    = 3'd2
  } pcSrc_t;

  // Everything the controller drives in one cycle
  typedef struct packed {
    logic    pcWrite;
    logic    irWrite;
    logic    regWrite;
    logic    abWrite;
    logic    aluOutWrite;
    aluOp_t  aluOp;
    srcA_t   aluSrcA;
    srcB_t   aluSrcB;
    regDst_t regDst;
    pcSrc_t  pcSource;
  } ctrlWord_t;

  // Comparator outputs from the datapath
  typedef struct packed {
    logic eq;
    logic gt;
  } aluFlags_t;

  // Low half of the instruction word
  typedef union packed {
    logic [15:0] imm;  // I-type view
    struct packed {
      logic [4:0] rd;
      logic [4:0] shamt;
      logic [5:0] funct;
    } rType;           // R-type view
  } instrLow_t;

endpackage

// ==== hw/opDecoder.sv ====
`timescale 1ns/10ps

module opDecoder
  import ctrlPkg::*;
(
  input  logic [5:0] opcode,
  input  instrLow_t  offset,
  output phase_t     nextPhase,
  output logic       known
);

  // Pure lookup; the sequencer samples it at the decode step
  always_comb begin
    nextPhase = phFetch;
    known     = 1'b1;
    case (opcode)
      opNull: begin
        case (offset.rType.funct)
          fnAdd: nextPhase = phAdd;
          fnSub: nextPhase = phSub;
          fnAnd: nextPhase = phAnd;
          default: begin
            // Shifts, mult/div and the rest go back to fetch
            nextPhase = phFetch;
            known     = 1'b0;
          end
        endcase
      end
      opAddi: nextPhase = phAddi;
      opBeq:  nextPhase = phBeq;
      opBne:  nextPhase = phBne;
      opBle:  nextPhase = phBle;
      opBgt:  nextPhase = phBgt;
      default: begin
        nextPhase = phFetch; // Loads, stores, jumps not supported
        known     = 1'b0;
      end
    endcase
  end

endmodule

// ==== hw/stepSequencer.sv ====
`timescale 1ns/10ps

module stepSequencer
  import ctrlPkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  phase_t nextPhase,
  input  logic   known,
  output phase_t phase,
  output step_t  step,
  output logic   datapathReset
);

  logic  stepLast; // Current step ends the phase
  step_t lastStep;

  // Length of the current phase
  always_comb begin
    case (phase)
      phFetch: lastStep = fetchLast;
      phAdd,
      phAddi,
      phSub,
      phAnd:   lastStep = aluExecLast;
      phBeq,
      phBne,
      phBle,
      phBgt:   lastStep = branchExecLast;
      default: lastStep = '0; // Reset phase lasts one step
    endcase
  end

  assign stepLast = (step == lastStep);

  always_ff @(posedge clk) begin
    if (reset) begin
      phase <= phReset;
      step  <= '0;
    end else begin
      if (stepLast) begin
        step <= '0;
        // Decode result is taken only at the end of fetch
        if (phase == phFetch && known) begin
          phase <= nextPhase;
        end else begin
          phase <= phFetch; // Unknown op, finished exec or reset exit
        end
      end else begin
        step <= step_t'(step + 1'b1);
      end
    end
  end

  // High for the reset phase, including the cycle after release
  assign datapathReset = (phase == phReset);

endmodule

// ==== hw/controlEncoder.sv ====
`timescale 1ns/10ps

module controlEncoder
  import ctrlPkg::*;
(
  input  phase_t    phase,
  input  step_t     step,
  input  aluFlags_t flags,
  output ctrlWord_t ctrl
);

  aluOp_t execOp;     // ALU op of the R-type/immediate phases
  logic   branchTake; // Condition of the current branch phase

  always_comb begin
    case (phase)
      phSub:   execOp = aluSub;
      phAnd:   execOp = aluAnd;
      default: execOp = aluAdd; // ADD and ADDI
    endcase
  end

  // Only place where branch conditions are evaluated
  always_comb begin
    case (phase)
      phBeq:   branchTake = flags.eq;
      phBne:   branchTake = !flags.eq;
      phBle:   branchTake = !flags.gt;
      phBgt:   branchTake = flags.gt;
      default: branchTake = 1'b0;
    endcase
  end

  always_comb begin
    ctrl = '0;
    case (phase)
      phFetch: begin
        if (step <= 3'd2) begin
          // Memory read in flight, PC+4 into ALUOut
          ctrl.aluOutWrite = 1'b1;
          ctrl.aluOp       = aluAdd;
          ctrl.aluSrcA     = srcAPc;
          ctrl.aluSrcB     = srcBFour;
          ctrl.pcSource    = pcAluResult;
        end else if (step == 3'd3) begin
          ctrl.pcWrite  = 1'b1;
          ctrl.irWrite  = 1'b1;
          ctrl.pcSource = pcAluOut;
        end else if (step == 3'd4) begin
          ctrl.abWrite = 1'b1; // Register file read into A/B
        end
        // Step 5 is the decode step, all zero
      end

      phAdd,
      phAddi,
      phSub,
      phAnd: begin
        if (step == 3'd0) begin
          ctrl.aluOutWrite = 1'b1;
          ctrl.aluOp       = execOp;
          ctrl.aluSrcA     = srcAA;
          ctrl.aluSrcB     = (phase == phAddi) ? srcBImm : srcBB;
        end else if (step == 3'd1) begin
          ctrl.regWrite = 1'b1;
          ctrl.regDst   = (phase == phAddi) ? dstRt : dstRd;
        end
      end

      phBeq,
      phBne,
      phBle,
      phBgt: begin
        if (step == 3'd0) begin
          // Branch target into ALUOut
          ctrl.aluOutWrite = 1'b1;
          ctrl.aluOp       = aluAdd;
          ctrl.aluSrcA     = srcAPc;
          ctrl.aluSrcB     = srcBBranch;
        end else if (step == 3'd1) begin
          ctrl.aluOp    = aluCmp; // Flags settle for next step
          ctrl.aluSrcA  = srcAA;
          ctrl.aluSrcB  = srcBB;
          ctrl.pcSource = pcAluOut;
        end else if (step == 3'd2) begin
          ctrl.pcSource = pcAluOut;
          ctrl.pcWrite  = branchTake;
        end
      end

      default: ctrl = '0; // Reset phase
    endcase
  end

endmodule

// ==== hw/ctrlUnit.sv ====
`timescale 1ns/10ps

module ctrlUnit
  import ctrlPkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic [5:0] opcode,
  input  instrLow_t  offset,
  input  aluFlags_t  flags,
  output ctrlWord_t  ctrl,
  output logic       datapathReset
);

  phase_t nextPhase;
  logic   known;
  phase_t phase;
  step_t  step;

  opDecoder decoder (
    .opcode   (opcode),
    .offset   (offset),
    .nextPhase(nextPhase),
    .known    (known)
  );

  stepSequencer sequencer (
    .clk          (clk),
    .reset        (reset),
    .nextPhase    (nextPhase),
    .known        (known),
    .phase        (phase),
    .step         (step),
    .datapathReset(datapathReset)
  );

  controlEncoder encoder (
    .phase(phase),
    .step (step),
    .flags(flags),
    .ctrl (ctrl)
  );

endmodule

// ==== tests/tbClock.sv ====
`timescale 1ns/10ps

module tbClock (
  output logic clk,
  output logic reset
);

  localparam int period      = 40;
  localparam int resetCycles = 3;

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  // Reset held for three rising edges, dropped on a falling edge
  initial begin
    reset = 1'b1;
    repeat (resetCycles) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  end

endmodule

// ==== tests/ctrlUnitTb.sv ====
`timescale 1ns/10ps

module ctrlUnitTb
  import ctrlPkg::*;
();

  localparam int patternCount  = 22;
  localparam int fieldCount    = 10;
  localparam int clkPeriod     = 40;
  localparam int resetCycles   = 3;
  localparam int maxCycles     = 16;
  localparam int timeoutCycles = patternCount * 12 + 20;

  // One line of the pattern file
  typedef struct packed {
    logic [5:0] opcode;
    instrLow_t  offset;
    aluFlags_t  flags;
    logic [3:0] execLen;
    aluOp_t     aluOp;  // Expected at execution step 0
    srcB_t      srcB;
    logic       regWrite;
    regDst_t    regDst;
    logic       taken;
  } pattern_t;

  logic       clk;
  logic       reset;
  logic [5:0] opcode;
  instrLow_t  offset;
  aluFlags_t  flags;
  ctrlWord_t  ctrl;
  logic       datapathReset;

  logic [15:0] raw [0:patternCount*fieldCount-1];
  pattern_t    pats [0:patternCount-1];
  int          passCount;
  int          failCount;
  int          i;

  tbClock clock (
    .clk  (clk),
    .reset(reset)
  );

  ctrlUnit DUT (
    .clk          (clk),
    .reset        (reset),
    .opcode       (opcode),
    .offset       (offset),
    .flags        (flags),
    .ctrl         (ctrl),
    .datapathReset(datapathReset)
  );

  task automatic loadPatterns();
    int b;
    int k;
    $readmemh("tests/ctrlPatterns.txt", raw);
    for (k = 0; k < patternCount; k++) begin
      b = k * fieldCount;
      pats[k].opcode   = raw[b][5:0];
      pats[k].offset   = instrLow_t'(raw[b+1]);
      pats[k].flags.eq = raw[b+2][0];
      pats[k].flags.gt = raw[b+3][0];
      pats[k].execLen  = raw[b+4][3:0];
      pats[k].aluOp    = aluOp_t'(raw[b+5][2:0]);
      pats[k].srcB     = srcB_t'(raw[b+6][1:0]);
      pats[k].regWrite = raw[b+7][0];
      pats[k].regDst   = regDst_t'(raw[b+8][1:0]);
      pats[k].taken    = raw[b+9][0];
    end
  endtask

  task automatic applyPattern(input pattern_t p);
    opcode = p.opcode;
    offset = p.offset;
    flags  = p.flags;
  endtask

  function automatic logic isFetchStart(input ctrlWord_t c);
    return c.aluOutWrite && c.aluSrcA == srcAPc && c.aluSrcB == srcBFour;
  endfunction

  // Expected control word for cycle k of an instruction, fetch included
  function automatic ctrlWord_t expectedWord(input pattern_t p, input int k);
    ctrlWord_t w;
    int        e;
    w = '0;
    e = k - 6;
    if (k <= 2) begin
      w.aluOutWrite = 1'b1;
      w.aluOp       = aluAdd;
      w.aluSrcA     = srcAPc;
      w.aluSrcB     = srcBFour;
      w.pcSource    = pcAluResult;
    end else if (k == 3) begin
      w.pcWrite  = 1'b1;
      w.irWrite  = 1'b1;
      w.pcSource = pcAluOut;
    end else if (k == 4) begin
      w.abWrite = 1'b1;
    end else if (p.execLen == 4'd3) begin
      if (e == 0) begin
        w.aluOutWrite = 1'b1;
        w.aluOp       = p.aluOp;
        w.aluSrcA     = srcAA;
        w.aluSrcB     = p.srcB;
      end else if (e == 1) begin
        w.regWrite = p.regWrite;
        w.regDst   = p.regDst;
      end
    end else if (p.execLen == 4'd4) begin
      if (e == 0) begin
        w.aluOutWrite = 1'b1; // Branch target
        w.aluOp       = p.aluOp;
        w.aluSrcA     = srcAPc;
        w.aluSrcB     = p.srcB;
      end else if (e == 1) begin
        w.aluOp    = aluCmp;
        w.aluSrcA  = srcAA;
        w.aluSrcB  = srcBB;
        w.pcSource = pcAluOut;
      end else if (e == 2) begin
        w.pcSource = pcAluOut;
        w.pcWrite  = p.taken;
      end
    end
    return w;
  endfunction

  task automatic checkReset();
    int   highCount;
    int   errs;
    logic stop;
    highCount = 0;
    errs      = 0;
    stop      = 1'b0;
    while (!stop) begin
      @(negedge clk);
      if (isFetchStart(ctrl)) begin
        stop = 1'b1;
      end else begin
        if (datapathReset !== 1'b1 || ctrl !== '0) begin
          $display("error at %0t: reset phase shows ctrl %h, datapathReset %b",
                   $time, ctrl, datapathReset);
          errs++;
        end
        highCount++;
        if (highCount > 2 * resetCycles + 2) begin
          $display("Reset phase never ended, fetch did not start");
          errs++;
          stop = 1'b1;
        end
      end
    end
    if (highCount != resetCycles) begin
      $display("error at %0t: %0d reset phase cycles, expected %0d",
               $time, highCount, resetCycles);
      errs++;
    end
    if (errs == 0) begin
      $display("reset: ok");
      passCount++;
    end else begin
      $display("reset: FAILED");
      failCount++;
    end
  endtask

  // Entered on the sample of fetch step 0, left on the next one
  task automatic runPattern(input int idx);
    pattern_t  p;
    pattern_t  filler;
    ctrlWord_t exp;
    int        n;
    int        errs;
    logic      prevZero;
    logic      done;
    p        = pats[idx];
    filler   = '0;
    filler.opcode = 6'h3f; // Unused opcode after the last pattern
    n        = 0;
    errs     = 0;
    prevZero = 1'b0;
    done     = 1'b0;
    while (!done) begin
      if (n > 0 && prevZero && isFetchStart(ctrl)) begin
        done = 1'b1;
      end else begin
        exp = expectedWord(p, n);
        if (ctrl !== exp) begin
          $display("error at %0t: pattern %0d cycle %0d ctrl %h, expected %h",
                   $time, idx, n, ctrl, exp);
          errs++;
        end
        if (datapathReset !== 1'b0) begin
          $display("error at %0t: pattern %0d datapathReset high in cycle %0d",
                   $time, idx, n);
          errs++;
        end
        prevZero = (ctrl == '0);
        n++;
        if (n >= maxCycles) begin
          $display("Pattern %0d never returned to fetch", idx);
          errs++;
          done = 1'b1;
        end else begin
          @(negedge clk);
        end
      end
    end
    // Next instruction goes in on its first fetch cycle and stays through decode
    if (idx + 1 < patternCount) begin
      applyPattern(pats[idx+1]);
    end else begin
      applyPattern(filler);
    end
    if (n != 6 + int'(p.execLen)) begin
      $display("error at %0t: pattern %0d took %0d cycles, expected %0d",
               $time, idx, n, 6 + int'(p.execLen));
      errs++;
    end
    if (errs == 0) begin
      $display("pattern %0d op %h offset %h: ok", idx, p.opcode, p.offset);
      passCount++;
    end else begin
      $display("pattern %0d op %h offset %h: FAILED", idx, p.opcode, p.offset);
      failCount++;
    end
  endtask

  initial begin
    opcode    = 6'h00;
    offset    = '0;
    flags     = '0;
    passCount = 0;
    failCount = 0;
    loadPatterns();
    applyPattern(pats[0]); // Held until its decode step
    checkReset();
    for (i = 0; i < patternCount; i++) begin
      runPattern(i);
    end
    $display("passed %0d, failed %0d", passCount, failCount);
    if (failCount == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(timeoutCycles * clkPeriod);
    $display("Run timed out after %0d cycles", timeoutCycles);
    $display("Some tests failed");
    $finish;
  end

endmodule

// ==== tests/ctrlPatterns.txt ====
// opcode offset eq gt execLen aluOp srcB regWrite regDst taken (hex words)
// aluOp and srcB are checked at execution step 0, taken at branch step 2
// opcodes: 00 R-type by funct, 08 ADDI, 04 BEQ, 05 BNE, 06 BLE, 07 BGT
00 1820 0 0 3 1 0 1 1 0 // ADD rd=3
00 1822 0 0 3 2 0 1 1 0 // SUB
00 1824 1 0 3 3 0 1 1 0 // AND
08 0010 0 1 3 1 2 1 0 0 // ADDI
04 0004 0 0 4 1 3 0 0 0
04 0004 0 1 4 1 3 0 0 0
04 0004 1 0 4 1 3 0 0 1
04 0004 1 1 4 1 3 0 0 1
05 0004 0 0 4 1 3 0 0 1
05 0004 0 1 4 1 3 0 0 1
05 0004 1 0 4 1 3 0 0 0
05 0004 1 1 4 1 3 0 0 0
06 fffc 0 0 4 1 3 0 0 1
06 fffc 0 1 4 1 3 0 0 0
06 fffc 1 0 4 1 3 0 0 1
06 fffc 1 1 4 1 3 0 0 0
07 0008 0 0 4 1 3 0 0 0
07 0008 0 1 4 1 3 0 0 1
07 0008 1 0 4 1 3 0 0 0
07 0008 1 1 4 1 3 0 0 1
00 1825 0 0 0 0 0 0 0 0 // OR funct, not supported
23 0008 1 1 0 0 0 0 0 0 // LW opcode, not supported

// ==== list.f ====
hw/ctrlPkg.sv
hw/opDecoder.sv
hw/stepSequencer.sv
hw/controlEncoder.sv
hw/ctrlUnit.sv
tests/tbClock.sv
tests/ctrlUnitTb.sv

// ==== Makefile ====
TOOL  = verilator
FLAGS = --binary --timing -j 0
TOP   = ctrlUnitTb
LIST  = list.f
BUILD = obj_dir
LOG   = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(LIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "Some tests failed" $(LOG) || ! grep -q "All tests passed" $(LOG); then \
		echo "FAIL"; exit 1; \
	else \
		echo "PASS"; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
